//--- hw/board_ctrl_pkg.sv
/*
  board control glue: shared widths, register map, SPI transfer states
*/
`default_nettype none

package board_ctrl_pkg;

  // ********************
  // widths
  // ********************

  localparam int GPIO_W     = 19;
  localparam int REG_AW     = 4;
  localparam int REG_DW     = 32;
  localparam int TRIG_CNT_W = 16;

  // SPI bus sizes
  localparam int CONV_CS_N      = 3;
  localparam int RF_CS_N        = 9;
  localparam int SPI_INSTR_BITS = 16;
  localparam int SPI_CNT_W      = $clog2(SPI_INSTR_BITS);

  // select lines of the two HMC271 attenuators on the RF bus
  localparam int RF_CS_HMC271_1 = 7;
  localparam int RF_CS_HMC271_2 = 8;

  // identification word at address 0
  localparam logic [REG_DW-1:0] BOARD_ID = 32'hB0A2_0719;

  // ********************
  // register map
  // ********************

  typedef enum logic [REG_AW-1:0] {
    REG_ID       = 4'd0,
    REG_GPIO_OUT = 4'd1,
    REG_GPIO_OE  = 4'd2,
    REG_GPIO_IN  = 4'd3,
    REG_TRIG_CNT = 4'd4,
    REG_STATUS   = 4'd5
  } reg_addr_e;

  // converter-bus transfer phases
  typedef enum logic [1:0] {
    SPI_IDLE  = 2'd0,
    SPI_INSTR = 2'd1,
    SPI_WRITE = 2'd2,
    SPI_READ  = 2'd3
  } spi_state_e;

endpackage

`default_nettype wire

//--- hw/gpio_bank.sv
/*
  board control pin bank: pad drive, input synchronisers,
  trigger edge detect and transmit-link sync merge
*/
`default_nettype none

module gpio_bank (
  input  wire logic                              sys_clk_i,
  input  wire logic                              arst_n_i,
  input  wire logic [board_ctrl_pkg::GPIO_W-1:0] gpio_out_i,
  input  wire logic [board_ctrl_pkg::GPIO_W-1:0] gpio_oe_i,
  input  wire logic [board_ctrl_pkg::GPIO_W-1:0] gpio_i,
  input  wire logic                              trig_i,
  input  wire logic                              tx_sync0_i,
  input  wire logic                              tx_sync1_i,
  output logic      [board_ctrl_pkg::GPIO_W-1:0] gpio_o,
  output logic      [board_ctrl_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic      [board_ctrl_pkg::GPIO_W-1:0] gpio_in_o,
  output logic                                   trig_pulse_o,
  output logic                                   tx_sync_o
);

  // ********************
  // pad inputs
  // ********************

  // all asynchronous pad inputs share one two-flop stage,
  // packed as {tx_sync1, tx_sync0, trig, gpio}
  logic [board_ctrl_pkg::GPIO_W+2:0] pad_s1_q;
  logic [board_ctrl_pkg::GPIO_W+2:0] pad_s2_q;
  logic                              trig_s3_q;

  logic                              trig_sync;
  logic                              sync0_sync;
  logic                              sync1_sync;

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pad_s1_q  <= '0;
      pad_s2_q  <= '0;
      trig_s3_q <= 1'b0;
    end else begin
      pad_s1_q  <= {tx_sync1_i, tx_sync0_i, trig_i, gpio_i};
      pad_s2_q  <= pad_s1_q;
      trig_s3_q <= trig_sync;
    end
  end

  assign trig_sync  = pad_s2_q[board_ctrl_pkg::GPIO_W];
  assign sync0_sync = pad_s2_q[board_ctrl_pkg::GPIO_W+1];
  assign sync1_sync = pad_s2_q[board_ctrl_pkg::GPIO_W+2];

  assign gpio_in_o = pad_s2_q[board_ctrl_pkg::GPIO_W-1:0];

  // one pulse per rising trigger edge
  assign trig_pulse_o = trig_sync & ~trig_s3_q;

  // both links must request sync
  assign tx_sync_o = sync0_sync & sync1_sync;

  // ********************
  // pad outputs
  // ********************

  // value and enable go straight to the split pad model
  assign gpio_o    = gpio_out_i;
  assign gpio_oe_o = gpio_oe_i;

  a_trig_pulse_single : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    trig_pulse_o |=> !trig_pulse_o);

endmodule

`default_nettype wire

//--- hw/board_regs.sv
/*
  host register block: steers the pin bank, counts trigger
  events and reports link and SPI status
*/
`default_nettype none

module board_regs (
  input  wire logic                              sys_clk_i,
  input  wire logic                              arst_n_i,
  input  wire logic                              reg_wr_i,
  input  wire logic                              reg_rd_i,
  input  wire logic [board_ctrl_pkg::REG_AW-1:0] reg_addr_i,
  input  wire logic [board_ctrl_pkg::REG_DW-1:0] reg_wdata_i,
  input  wire logic [board_ctrl_pkg::GPIO_W-1:0] gpio_in_i,
  input  wire logic                              trig_pulse_i,
  input  wire logic                              link_sync_i,
  input  wire logic                              spi_driving_i,
  output logic      [board_ctrl_pkg::REG_DW-1:0] reg_rdata_o,
  output logic                                   reg_rvalid_o,
  output logic      [board_ctrl_pkg::GPIO_W-1:0] gpio_out_o,
  output logic      [board_ctrl_pkg::GPIO_W-1:0] gpio_oe_o
);

  board_ctrl_pkg::reg_addr_e addr;

  logic [board_ctrl_pkg::GPIO_W-1:0]     gpio_out_q;
  logic [board_ctrl_pkg::GPIO_W-1:0]     gpio_oe_q;
  logic [board_ctrl_pkg::TRIG_CNT_W-1:0] trig_cnt_q;
  logic                                  sync_lost_q;
  logic                                  link_sync_q;
  logic [board_ctrl_pkg::REG_DW-1:0]     rd_data;
  logic [board_ctrl_pkg::REG_DW-1:0]     rdata_q;
  logic                                  rvalid_q;

  assign addr = board_ctrl_pkg::reg_addr_e'(reg_addr_i);

  // ********************
  // writable state
  // ********************

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q  <= '0;
      gpio_oe_q   <= '0;
      trig_cnt_q  <= '0;
      sync_lost_q <= 1'b0;
      link_sync_q <= 1'b0;
    end else begin
      link_sync_q <= link_sync_i;

      if (reg_wr_i && addr == board_ctrl_pkg::REG_GPIO_OUT) begin
        gpio_out_q <= reg_wdata_i[board_ctrl_pkg::GPIO_W-1:0];
      end
      if (reg_wr_i && addr == board_ctrl_pkg::REG_GPIO_OE) begin
        gpio_oe_q <= reg_wdata_i[board_ctrl_pkg::GPIO_W-1:0];
      end

      // any write clears, otherwise count up and stick at the top
      if (reg_wr_i && addr == board_ctrl_pkg::REG_TRIG_CNT) begin
        trig_cnt_q <= '0;
      end else if (trig_pulse_i && !(&trig_cnt_q)) begin
        trig_cnt_q <= trig_cnt_q + 1'b1;
      end

      // a new loss of sync wins over a clear in the same cycle
      if (link_sync_q && !link_sync_i) begin
        sync_lost_q <= 1'b1;
      end else if (reg_wr_i && addr == board_ctrl_pkg::REG_STATUS && reg_wdata_i[1]) begin
        sync_lost_q <= 1'b0;
      end
    end
  end

  // ********************
  // read path
  // ********************

  always_comb begin
    rd_data = '0;
    case (addr)
      board_ctrl_pkg::REG_ID:       rd_data = board_ctrl_pkg::BOARD_ID;
      board_ctrl_pkg::REG_GPIO_OUT: rd_data[board_ctrl_pkg::GPIO_W-1:0] = gpio_out_q;
      board_ctrl_pkg::REG_GPIO_OE:  rd_data[board_ctrl_pkg::GPIO_W-1:0] = gpio_oe_q;
      board_ctrl_pkg::REG_GPIO_IN:  rd_data[board_ctrl_pkg::GPIO_W-1:0] = gpio_in_i;
      board_ctrl_pkg::REG_TRIG_CNT: rd_data[board_ctrl_pkg::TRIG_CNT_W-1:0] = trig_cnt_q;
      board_ctrl_pkg::REG_STATUS:   rd_data[2:0] = {spi_driving_i, sync_lost_q, link_sync_i};
      default:                      rd_data = '0;
    endcase
  end

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_rd_i;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (reg_rd_i) begin
      rdata_q <= rd_data;
    end
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;
  assign gpio_out_o   = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;

  a_rvalid_needs_read : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    reg_rvalid_o |-> $past(reg_rd_i));

endmodule

`default_nettype wire

//--- hw/spi_pin_ctrl.sv
/*
  SPI pin control: three-wire direction tracking on the converter bus,
  chip-select fan-out and readback select on the RF bus
*/
`default_nettype none

module spi_pin_ctrl (
  input  wire logic                                 sys_clk_i,
  input  wire logic                                 arst_n_i,
  input  wire logic [board_ctrl_pkg::CONV_CS_N-1:0] conv_csn_i,
  input  wire logic                                 conv_sclk_i,
  input  wire logic                                 conv_mosi_i,
  input  wire logic                                 conv_sdio_i,
  input  wire logic [board_ctrl_pkg::RF_CS_N-1:0]   rf_csn_i,
  input  wire logic                                 rf_mosi_i,
  input  wire logic [1:0]                           rf_sdi_hmc271_i,
  output logic                                      conv_miso_o,
  output logic                                      conv_sdio_o,
  output logic                                      spi_dir_o,
  output logic [board_ctrl_pkg::RF_CS_N-1:0]        rf_dev_csn_o,
  output logic                                      rf_sdo_o,
  output logic                                      rf_miso_o
);

  // sampled converter pads, packed as {mosi, sclk, csn}
  logic [board_ctrl_pkg::CONV_CS_N+1:0] conv_s1_q;
  logic [board_ctrl_pkg::CONV_CS_N+1:0] conv_s2_q;
  logic                                 sclk_s3_q;

  logic [board_ctrl_pkg::CONV_CS_N-1:0] csn_sync;
  logic                                 sclk_sync;
  logic                                 mosi_sync;
  logic                                 sclk_rise;
  logic                                 cs_idle;

  logic [board_ctrl_pkg::SPI_CNT_W-1:0] bit_cnt_q;
  logic                                 first_bit_q;
  logic                                 spi_drive;

  board_ctrl_pkg::spi_state_e state_q;
  board_ctrl_pkg::spi_state_e state_d;

  // ********************
  // converter bus sampling
  // ********************

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // selects come out of reset inactive
      conv_s1_q <= {2'b00, {board_ctrl_pkg::CONV_CS_N{1'b1}}};
      conv_s2_q <= {2'b00, {board_ctrl_pkg::CONV_CS_N{1'b1}}};
      sclk_s3_q <= 1'b0;
    end else begin
      conv_s1_q <= {conv_mosi_i, conv_sclk_i, conv_csn_i};
      conv_s2_q <= conv_s1_q;
      sclk_s3_q <= sclk_sync;
    end
  end

  assign csn_sync  = conv_s2_q[board_ctrl_pkg::CONV_CS_N-1:0];
  assign sclk_sync = conv_s2_q[board_ctrl_pkg::CONV_CS_N];
  assign mosi_sync = conv_s2_q[board_ctrl_pkg::CONV_CS_N+1];
  assign sclk_rise = sclk_sync & ~sclk_s3_q;
  assign cs_idle   = &csn_sync;

  // ********************
  // transfer phase tracking
  // ********************

  always_comb begin
    state_d = state_q;
    case (state_q)
      board_ctrl_pkg::SPI_IDLE: begin
        if (!cs_idle) begin
          state_d = board_ctrl_pkg::SPI_INSTR;
        end
      end
      board_ctrl_pkg::SPI_INSTR: begin
        // the last instruction edge decides the data phase
        if (sclk_rise &&
            bit_cnt_q == board_ctrl_pkg::SPI_CNT_W'(board_ctrl_pkg::SPI_INSTR_BITS - 1)) begin
          state_d = first_bit_q ? board_ctrl_pkg::SPI_READ : board_ctrl_pkg::SPI_WRITE;
        end
      end
      default: begin
        state_d = state_q;
      end
    endcase
    // deselect ends any transfer
    if (cs_idle) begin
      state_d = board_ctrl_pkg::SPI_IDLE;
    end
  end

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= board_ctrl_pkg::SPI_IDLE;
      bit_cnt_q   <= '0;
      first_bit_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == board_ctrl_pkg::SPI_IDLE) begin
        bit_cnt_q   <= '0;
        first_bit_q <= 1'b0;
      end else if (state_q == board_ctrl_pkg::SPI_INSTR && sclk_rise) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        // first bit is the read/write flag
        if (bit_cnt_q == '0) begin
          first_bit_q <= mosi_sync;
        end
      end
    end
  end

  // board drives sdio except in the read data phase
  assign spi_drive   = (state_q != board_ctrl_pkg::SPI_READ);
  assign spi_dir_o   = spi_drive;
  assign conv_sdio_o = conv_mosi_i;
  assign conv_miso_o = spi_drive ? 1'b0 : conv_sdio_i;

  // ********************
  // RF bus fan-out
  // ********************

  assign rf_dev_csn_o = rf_csn_i;
  assign rf_sdo_o     = rf_mosi_i;
  assign rf_miso_o    = (~rf_csn_i[board_ctrl_pkg::RF_CS_HMC271_1] & rf_sdi_hmc271_i[0]) |
                        (~rf_csn_i[board_ctrl_pkg::RF_CS_HMC271_2] & rf_sdi_hmc271_i[1]);

  // selects idle long enough to pass the sampling flops force idle
  a_idle_when_deselected : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    (&conv_csn_i) [*3] |=> (state_q == board_ctrl_pkg::SPI_IDLE));

  a_one_hmc271_selected : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    (rf_csn_i[board_ctrl_pkg::RF_CS_HMC271_1] | rf_csn_i[board_ctrl_pkg::RF_CS_HMC271_2]));

endmodule

`default_nettype wire

//--- hw/board_ctrl_top.sv
/*
  board control glue top: register block, pin bank and SPI pin control
*/
`default_nettype none

module board_ctrl_top (
  input  wire logic                                 sys_clk_i,
  input  wire logic                                 arst_n_i,
  // host register port
  input  wire logic                                 reg_wr_i,
  input  wire logic                                 reg_rd_i,
  input  wire logic [board_ctrl_pkg::REG_AW-1:0]    reg_addr_i,
  input  wire logic [board_ctrl_pkg::REG_DW-1:0]    reg_wdata_i,
  output logic      [board_ctrl_pkg::REG_DW-1:0]    reg_rdata_o,
  output logic                                      reg_rvalid_o,
  // board control pins
  input  wire logic [board_ctrl_pkg::GPIO_W-1:0]    gpio_i,
  output logic      [board_ctrl_pkg::GPIO_W-1:0]    gpio_o,
  output logic      [board_ctrl_pkg::GPIO_W-1:0]    gpio_oe_o,
  input  wire logic                                 trig_i,
  input  wire logic                                 tx_sync0_i,
  input  wire logic                                 tx_sync1_i,
  output logic                                      tx_sync_o,
  // converter bus
  input  wire logic [board_ctrl_pkg::CONV_CS_N-1:0] conv_csn_i,
  input  wire logic                                 conv_sclk_i,
  input  wire logic                                 conv_mosi_i,
  output logic                                      conv_miso_o,
  input  wire logic                                 conv_sdio_i,
  output logic                                      conv_sdio_o,
  output logic                                      spi_dir_o,
  // RF device bus
  input  wire logic [board_ctrl_pkg::RF_CS_N-1:0]   rf_csn_i,
  input  wire logic                                 rf_mosi_i,
  output logic                                      rf_miso_o,
  output logic      [board_ctrl_pkg::RF_CS_N-1:0]   rf_dev_csn_o,
  output logic                                      rf_sdo_o,
  input  wire logic [1:0]                           rf_sdi_hmc271_i
);

  logic [board_ctrl_pkg::GPIO_W-1:0] gpio_out;
  logic [board_ctrl_pkg::GPIO_W-1:0] gpio_oe;
  logic [board_ctrl_pkg::GPIO_W-1:0] gpio_in_sync;
  logic                              trig_pulse;

  board_regs i_board_regs (
    .sys_clk_i     (sys_clk_i),
    .arst_n_i      (arst_n_i),
    .reg_wr_i      (reg_wr_i),
    .reg_rd_i      (reg_rd_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .gpio_in_i     (gpio_in_sync),
    .trig_pulse_i  (trig_pulse),
    .link_sync_i   (tx_sync_o),
    .spi_driving_i (spi_dir_o),
    .reg_rdata_o   (reg_rdata_o),
    .reg_rvalid_o  (reg_rvalid_o),
    .gpio_out_o    (gpio_out),
    .gpio_oe_o     (gpio_oe));

  gpio_bank i_gpio_bank (
    .sys_clk_i    (sys_clk_i),
    .arst_n_i     (arst_n_i),
    .gpio_out_i   (gpio_out),
    .gpio_oe_i    (gpio_oe),
    .gpio_i       (gpio_i),
    .trig_i       (trig_i),
    .tx_sync0_i   (tx_sync0_i),
    .tx_sync1_i   (tx_sync1_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .gpio_in_o    (gpio_in_sync),
    .trig_pulse_o (trig_pulse),
    .tx_sync_o    (tx_sync_o));

  spi_pin_ctrl i_spi_pin_ctrl (
    .sys_clk_i       (sys_clk_i),
    .arst_n_i        (arst_n_i),
    .conv_csn_i      (conv_csn_i),
    .conv_sclk_i     (conv_sclk_i),
    .conv_mosi_i     (conv_mosi_i),
    .conv_sdio_i     (conv_sdio_i),
    .rf_csn_i        (rf_csn_i),
    .rf_mosi_i       (rf_mosi_i),
    .rf_sdi_hmc271_i (rf_sdi_hmc271_i),
    .conv_miso_o     (conv_miso_o),
    .conv_sdio_o     (conv_sdio_o),
    .spi_dir_o       (spi_dir_o),
    .rf_dev_csn_o    (rf_dev_csn_o),
    .rf_sdo_o        (rf_sdo_o),
    .rf_miso_o       (rf_miso_o));

endmodule

`default_nettype wire

//--- bench/board_ctrl_tb.sv
/*
  board control glue testbench: directed tests of the register port,
  pin bank, link sync merge and both SPI buses
*/
`default_nettype none

module board_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 20;
  localparam int SPI_HALF   = 3;
  // cycle budget per test: reset, regs, gpio in, trigger, link, SPI, RF
  localparam int RUN_CYCLES = 10 + 20 + 80 + 40 + 16 * 10 + 30 + 50 +
                              2 * (24 * 2 * SPI_HALF + 10) + 20;
  localparam int MARGIN_CYCLES = 200;

  logic                                 sys_clk;
  logic                                 arst_n;
  logic                                 reg_wr;
  logic                                 reg_rd;
  logic [board_ctrl_pkg::REG_AW-1:0]    reg_addr;
  logic [board_ctrl_pkg::REG_DW-1:0]    reg_wdata;
  logic [board_ctrl_pkg::REG_DW-1:0]    reg_rdata;
  logic                                 reg_rvalid;
  logic [board_ctrl_pkg::GPIO_W-1:0]    gpio_in;
  logic [board_ctrl_pkg::GPIO_W-1:0]    gpio_out;
  logic [board_ctrl_pkg::GPIO_W-1:0]    gpio_oe;
  logic                                 trig;
  logic                                 tx_sync0;
  logic                                 tx_sync1;
  logic                                 tx_sync;
  logic [board_ctrl_pkg::CONV_CS_N-1:0] conv_csn;
  logic                                 conv_sclk;
  logic                                 conv_mosi;
  logic                                 conv_miso;
  logic                                 conv_sdio_in;
  logic                                 conv_sdio_out;
  logic                                 spi_dir;
  logic [board_ctrl_pkg::RF_CS_N-1:0]   rf_csn;
  logic                                 rf_mosi;
  logic                                 rf_miso;
  logic [board_ctrl_pkg::RF_CS_N-1:0]   rf_dev_csn;
  logic                                 rf_sdo;
  logic [1:0]                           rf_sdi;

  int          errors;
  logic [15:0] lfsr;

  board_ctrl_top i_board_ctrl_top (
    .sys_clk_i       (sys_clk),
    .arst_n_i        (arst_n),
    .reg_wr_i        (reg_wr),
    .reg_rd_i        (reg_rd),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .reg_rdata_o     (reg_rdata),
    .reg_rvalid_o    (reg_rvalid),
    .gpio_i          (gpio_in),
    .gpio_o          (gpio_out),
    .gpio_oe_o       (gpio_oe),
    .trig_i          (trig),
    .tx_sync0_i      (tx_sync0),
    .tx_sync1_i      (tx_sync1),
    .tx_sync_o       (tx_sync),
    .conv_csn_i      (conv_csn),
    .conv_sclk_i     (conv_sclk),
    .conv_mosi_i     (conv_mosi),
    .conv_miso_o     (conv_miso),
    .conv_sdio_i     (conv_sdio_in),
    .conv_sdio_o     (conv_sdio_out),
    .spi_dir_o       (spi_dir),
    .rf_csn_i        (rf_csn),
    .rf_mosi_i       (rf_mosi),
    .rf_miso_o       (rf_miso),
    .rf_dev_csn_o    (rf_dev_csn),
    .rf_sdo_o        (rf_sdo),
    .rf_sdi_hmc271_i (rf_sdi));

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  // ********************
  // helpers
  // ********************

  // galois step, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
    return value;
  endfunction

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("mismatch in %s: expected 0x%h, actual 0x%h", test, expected, actual);
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge sys_clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge sys_clk);
    reg_wr    <= 1'b0;
  endtask

  // read strobe, then wait for the single valid cycle
  task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
    int waited;
    @(posedge sys_clk);
    reg_rd   <= 1'b1;
    reg_addr <= addr;
    @(posedge sys_clk);
    reg_rd   <= 1'b0;
    waited = 0;
    @(negedge sys_clk);
    while (!reg_rvalid && waited < 8) begin
      @(negedge sys_clk);
      waited++;
    end
    if (!reg_rvalid) begin
      errors++;
      $display("read of address %0d never returned a valid strobe", addr);
      data = 'x;
    end else begin
      data = reg_rdata;
      @(negedge sys_clk);
      if (reg_rvalid) begin
        errors++;
        $display("read valid stayed high for more than one cycle at address %0d", addr);
      end
    end
  endtask

  // ********************
  // tests
  // ********************

  task automatic check_reset();
    logic [31:0] data;
    @(negedge sys_clk);
    if (gpio_out !== '0) report_mismatch("reset gpio_o", 32'd0, 32'(gpio_out));
    if (gpio_oe !== '0) report_mismatch("reset gpio_oe_o", 32'd0, 32'(gpio_oe));
    if (spi_dir !== 1'b1) report_mismatch("reset spi_dir_o", 32'd1, 32'(spi_dir));
    if (tx_sync !== 1'b0) report_mismatch("reset tx_sync_o", 32'd0, 32'(tx_sync));
    if (reg_rvalid !== 1'b0) report_mismatch("reset reg_rvalid_o", 32'd0, 32'(reg_rvalid));
    reg_read(board_ctrl_pkg::REG_TRIG_CNT, data);
    if (data !== 32'd0) report_mismatch("reset trigger count", 32'd0, data);
    // only the SPI driving bit is set while idle
    reg_read(board_ctrl_pkg::REG_STATUS, data);
    if (data !== 32'h4) report_mismatch("reset status", 32'h4, data);
  endtask

  task automatic test_regs_gpio();
    logic [31:0] data;
    logic [31:0] out_word;
    logic [31:0] oe_word;
    reg_read(board_ctrl_pkg::REG_ID, data);
    if (data !== board_ctrl_pkg::BOARD_ID) report_mismatch("id", board_ctrl_pkg::BOARD_ID, data);
    for (int i = 0; i < 4; i++) begin
      out_word = rand_bits(board_ctrl_pkg::GPIO_W);
      oe_word  = rand_bits(board_ctrl_pkg::GPIO_W);
      reg_write(board_ctrl_pkg::REG_GPIO_OUT, out_word);
      @(negedge sys_clk);
      if (32'(gpio_out) !== out_word) report_mismatch("gpio_o drive", out_word, 32'(gpio_out));
      reg_write(board_ctrl_pkg::REG_GPIO_OE, oe_word);
      @(negedge sys_clk);
      if (32'(gpio_oe) !== oe_word) report_mismatch("gpio_oe_o drive", oe_word, 32'(gpio_oe));
      reg_read(board_ctrl_pkg::REG_GPIO_OUT, data);
      if (data !== out_word) report_mismatch("gpio out readback", out_word, data);
      reg_read(board_ctrl_pkg::REG_GPIO_OE, data);
      if (data !== oe_word) report_mismatch("gpio oe readback", oe_word, data);
    end
    reg_read(4'd9, data);
    if (data !== 32'd0) report_mismatch("unmapped read", 32'd0, data);
  endtask

  task automatic test_gpio_in();
    logic [31:0] data;
    logic [31:0] pads;
    for (int i = 0; i < 4; i++) begin
      pads = rand_bits(board_ctrl_pkg::GPIO_W);
      @(posedge sys_clk);
      gpio_in <= pads[board_ctrl_pkg::GPIO_W-1:0];
      repeat (3) @(posedge sys_clk);
      reg_read(board_ctrl_pkg::REG_GPIO_IN, data);
      if (data !== pads) report_mismatch("gpio input", pads, data);
    end
  endtask

  task automatic test_trigger();
    logic [31:0] data;
    int pulses;
    int width;
    int gap;
    reg_write(board_ctrl_pkg::REG_TRIG_CNT, 32'd0);
    pulses = 1 + int'(rand_bits(4));
    for (int i = 0; i < pulses; i++) begin
      width = 2 + int'(rand_bits(2));
      gap   = 2 + int'(rand_bits(2));
      @(posedge sys_clk);
      trig <= 1'b1;
      repeat (width) @(posedge sys_clk);
      trig <= 1'b0;
      repeat (gap - 1) @(posedge sys_clk);
    end
    repeat (4) @(posedge sys_clk);
    reg_read(board_ctrl_pkg::REG_TRIG_CNT, data);
    if (data !== 32'(pulses)) report_mismatch("trigger count", 32'(pulses), data);
    // the written value does not matter
    reg_write(board_ctrl_pkg::REG_TRIG_CNT, rand_bits(32));
    reg_read(board_ctrl_pkg::REG_TRIG_CNT, data);
    if (data !== 32'd0) report_mismatch("trigger count clear", 32'd0, data);
  endtask

  task automatic test_link_sync();
    logic [31:0] data;
    logic [1:0]  combo;
    for (int i = 0; i < 4; i++) begin
      combo = 2'(i);
      @(posedge sys_clk);
      tx_sync0 <= combo[0];
      tx_sync1 <= combo[1];
      repeat (3) @(posedge sys_clk);
      @(negedge sys_clk);
      if (tx_sync !== (combo[0] & combo[1])) begin
        report_mismatch("tx_sync_o merge", 32'(combo[0] & combo[1]), 32'(tx_sync));
      end
    end
    reg_read(board_ctrl_pkg::REG_STATUS, data);
    if (data !== 32'h5) report_mismatch("status in sync", 32'h5, data);
    @(posedge sys_clk);
    tx_sync1 <= 1'b0;
    repeat (3) @(posedge sys_clk);
    reg_read(board_ctrl_pkg::REG_STATUS, data);
    if (data !== 32'h6) report_mismatch("status sync lost", 32'h6, data);
    reg_write(board_ctrl_pkg::REG_STATUS, 32'h2);
    reg_read(board_ctrl_pkg::REG_STATUS, data);
    if (data !== 32'h4) report_mismatch("status sync lost clear", 32'h4, data);
  endtask

  // n cycles, checking direction, driven data and readback at each falling clock
  task automatic spi_wait(input int n, input logic board_drives, input string test);
    repeat (n) begin
      @(negedge sys_clk);
      if (spi_dir !== board_drives) report_mismatch(test, 32'(board_drives), 32'(spi_dir));
      if (board_drives && conv_sdio_out !== conv_mosi) begin
        report_mismatch({test, " sdio"}, 32'(conv_mosi), 32'(conv_sdio_out));
      end
      if (!board_drives && conv_miso !== conv_sdio_in) begin
        report_mismatch({test, " miso"}, 32'(conv_sdio_in), 32'(conv_miso));
      end
      @(posedge sys_clk);
    end
  endtask

  task automatic spi_bit(input logic mosi_bit, input logic sdio_bit, input logic drives_low,
                         input logic drives_high, input string test);
    conv_mosi    <= mosi_bit;
    conv_sdio_in <= sdio_bit;
    conv_sclk    <= 1'b0;
    spi_wait(SPI_HALF, drives_low, test);
    conv_sclk    <= 1'b1;
    spi_wait(SPI_HALF, drives_high, test);
  endtask

  // 16 instruction bits then 8 data bits, msb first
  task automatic spi_transfer(input logic [23:0] word, input logic is_read);
    string       test;
    logic [31:0] sel;
    logic [31:0] sdio_bit;
    test = is_read ? "spi read" : "spi write";
    sel  = rand_bits(2) % 3;
    @(posedge sys_clk);
    conv_csn <= ~(3'b001 << sel);
    spi_wait(SPI_HALF, 1'b1, test);
    for (int i = 23; i >= 0; i--) begin
      if (i >= 8) begin
        spi_bit(word[i], 1'b0, 1'b1, 1'b1, test);
      end else begin
        sdio_bit = rand_bits(1);
        spi_bit(word[i], sdio_bit[0], !is_read, !is_read, test);
      end
    end
    conv_sclk    <= 1'b0;
    conv_csn     <= '1;
    conv_sdio_in <= 1'b0;
    repeat (3) @(posedge sys_clk);
    @(negedge sys_clk);
    if (spi_dir !== 1'b1) report_mismatch({test, " deselect"}, 32'd1, 32'(spi_dir));
  endtask

  task automatic test_conv_spi();
    logic [31:0] bits;
    bits = rand_bits(23);
    spi_transfer({1'b0, bits[22:0]}, 1'b0);
    bits = rand_bits(23);
    spi_transfer({1'b1, bits[22:0]}, 1'b1);
  endtask

  task automatic test_rf_bus();
    logic [31:0]                        bits;
    logic [board_ctrl_pkg::RF_CS_N-1:0] csn;
    logic                               expected;
    for (int i = 0; i < 6; i++) begin
      bits = rand_bits(board_ctrl_pkg::RF_CS_N + 3);
      csn  = bits[board_ctrl_pkg::RF_CS_N-1:0];
      csn[board_ctrl_pkg::RF_CS_HMC271_1] = (i % 3 != 1);
      csn[board_ctrl_pkg::RF_CS_HMC271_2] = (i % 3 != 2);
      @(posedge sys_clk);
      rf_csn  <= csn;
      rf_mosi <= bits[9];
      rf_sdi  <= bits[11:10];
      @(negedge sys_clk);
      expected = (i % 3 == 1) ? bits[10] : ((i % 3 == 2) ? bits[11] : 1'b0);
      if (rf_dev_csn !== csn) report_mismatch("rf select fan-out", 32'(csn), 32'(rf_dev_csn));
      if (rf_sdo !== bits[9]) report_mismatch("rf data out", 32'(bits[9]), 32'(rf_sdo));
      if (rf_miso !== expected) report_mismatch("rf readback", 32'(expected), 32'(rf_miso));
    end
    @(posedge sys_clk);
    rf_csn <= '1;
  endtask

  // ********************
  // run
  // ********************

  initial begin
    errors       = 0;
    lfsr         = 16'd35530;
    sys_clk      = 1'b0;
    arst_n       = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    gpio_in      = '0;
    trig         = 1'b0;
    tx_sync0     = 1'b0;
    tx_sync1     = 1'b0;
    conv_csn     = '1;
    conv_sclk    = 1'b0;
    conv_mosi    = 1'b0;
    conv_sdio_in = 1'b0;
    rf_csn       = '1;
    rf_mosi      = 1'b0;
    rf_sdi       = '0;
    repeat (10) @(posedge sys_clk);
    arst_n <= 1'b1;
    check_reset();
    test_regs_gpio();
    test_gpio_in();
    test_trigger();
    test_link_sync();
    test_conv_spi();
    test_rf_bus();
    $display("tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: tests still running after %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hw/board_ctrl_pkg.sv
hw/gpio_bank.sv
hw/board_regs.sv
hw/spi_pin_ctrl.sv
hw/board_ctrl_top.sv
bench/board_ctrl_tb.sv

//--- Makefile
# Verilator build and run for the board control glue testbench

VERILATOR ?= verilator
TOP       ?= board_ctrl_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then \
	  echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
